// ==== compute_core.sv ====
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module compute_core import gpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  core_cfg_t cfg,
    output logic      imem_valid,
    output iaddr_t    imem_address,
    input  logic      imem_ready,
    input  instr_u    imem_data,
    output wb_t       wb,
    output logic      done
);

    buf_push_t push;
    buf_pop_t  pop;
    retire_t   retire;
    logic [`NUM_WARPS-1:0] slot_full;
    instr_u    slots [`NUM_WARPS];

    // Producer side, talks to instruction memory
    warp_fetcher fetcher (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .cfg          (cfg),
        .imem_valid   (imem_valid),
        .imem_address (imem_address),
        .imem_ready   (imem_ready),
        .imem_data    (imem_data),
        .slot_full    (slot_full),
        .retire       (retire),
        .push         (push)
    );

    instr_buffer ibuf (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .pop       (pop),
        .slot_full (slot_full),
        .slots     (slots)
    );

    // Consumer side, one issue per cycle
    warp_executor executor (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .cfg       (cfg),
        .slot_full (slot_full),
        .slots     (slots),
        .pop       (pop),
        .retire    (retire),
        .wb        (wb),
        .done      (done)
    );

endmodule

// ==== compute_core_patterns.txt ====
# i addr word | c num_warps base_address | e warp rd lane0 lane1 lane2 lane3 after_sync
# All values hex, e lines belong to the c line above them
i 10 62000000
i 11 5443fffd
i 12 80000000
i 13 70000015
i 14 4c480000
i 15 36500000
i 16 f0000000
i 20 18500000
i 21 2ac80000
i 22 4d280000
i 23 f0000000
c 4 10
e 0 1 00000000 00000001 00000002 00000003 0
e 0 2 fffffffd fffffffe ffffffff 00000000 0
e 0 3 00000000 00000000 00000002 00000000 1
e 1 1 00000004 00000005 00000006 00000007 0
e 1 2 00000001 00000002 00000003 00000004 0
e 1 3 00000000 00000000 00000002 00000004 1
e 2 1 00000008 00000009 0000000a 0000000b 0
e 2 2 00000005 00000006 00000007 00000008 0
e 2 3 00000000 00000000 00000002 00000008 1
e 3 1 0000000c 0000000d 0000000e 0000000f 0
e 3 2 00000009 0000000a 0000000b 0000000c 0
e 3 3 00000008 00000008 0000000a 0000000c 1
c 2 20
e 0 4 fffffffd ffffffff 00000001 00000003 0
e 0 5 00000000 ffffffff 00000000 fffffffd 0
e 0 6 fffffffd 00000000 00000001 fffffffe 0
e 1 4 00000005 00000007 00000009 0000000b 0
e 1 5 fffffffc fffffffb fffffffc fffffffd 0
e 1 6 fffffff9 fffffffc fffffff5 fffffff6 0

// ==== gpu_cfg.svh ====
`ifndef GPU_CFG_SVH
`define GPU_CFG_SVH

// Core geometry
`define NUM_WARPS   4
`define NUM_LANES   4
`define NUM_REGS    8

// Datapath and instruction address widths
`define DATA_WIDTH  32
`define IADDR_WIDTH 8

// Vector integer ops
`define OP_ADD      4'h1
`define OP_SUB      4'h2
`define OP_AND      4'h3
`define OP_XOR      4'h4
`define OP_ADDI     4'h5
`define OP_TID      4'h6

// Control flow
`define OP_JAL      4'h7
`define OP_SYNC     4'h8
`define OP_HALT     4'hf

`endif

// ==== gpu_pkg.sv ====
package gpu_pkg;

`include "gpu_cfg.svh"

    typedef logic [1:0] warp_id_t;
    typedef logic [2:0] reg_addr_t;
    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [`IADDR_WIDTH-1:0] iaddr_t;

    // Register form, used by the three-operand ALU ops
    typedef struct packed {
        logic [3:0] opcode;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic [18:0] pad;
    } instr_r_t;

    // Immediate form, used by ADDI and JAL
    typedef struct packed {
        logic [3:0]         opcode;
        reg_addr_t          rd;
        reg_addr_t          rs1;
        logic [3:0]         pad;
        logic signed [17:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        logic [2:0] num_warps;
        iaddr_t     base_address;
    } core_cfg_t;

    typedef struct packed {
        logic     valid;
        warp_id_t warp;
        instr_u   instr;
    } buf_push_t;

    typedef struct packed {
        logic     valid;
        warp_id_t warp;
    } buf_pop_t;

    typedef struct packed {
        logic [`NUM_WARPS-1:0] mask;
        logic                  jump;
        warp_id_t              jump_warp;
        iaddr_t                jump_target;
    } retire_t;

    // Lane 0 sits in the low word
    typedef struct packed {
        logic                                   valid;
        warp_id_t                               warp;
        reg_addr_t                              rd;
        logic [`NUM_LANES-1:0][`DATA_WIDTH-1:0] lanes;
    } wb_t;

    // Warps below n take part in the kernel
    function automatic logic [`NUM_WARPS-1:0] launch_mask(logic [2:0] n);
        logic [`NUM_WARPS-1:0] m;
        for (int i = 0; i < `NUM_WARPS; i++) begin
            m[i] = (i < n);
        end
        return m;
    endfunction

    // First requester after last, wrapping; nearest one wins
    function automatic warp_id_t rr_pick(logic [`NUM_WARPS-1:0] req, warp_id_t last);
        warp_id_t pick;
        warp_id_t cand;
        pick = last;
        for (int k = `NUM_WARPS; k >= 1; k--) begin
            cand = warp_id_t'(last + k);
            if (req[cand]) begin
                pick = cand;
            end
        end
        return pick;
    endfunction

endpackage

// ==== instr_buffer.sv ====
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module instr_buffer import gpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  buf_push_t             push,
    input  buf_pop_t              pop,
    output logic [`NUM_WARPS-1:0] slot_full,
    output instr_u                slots [`NUM_WARPS]
);

    // One full bit per warp
    always_ff @(posedge clk) begin
        if (reset) begin
            slot_full <= '0;
        end else begin
            // Push and pop target different warps when both fire
            if (pop.valid) begin
                slot_full[pop.warp] <= 1'b0;
            end
            if (push.valid) begin
                slot_full[push.warp] <= 1'b1;
            end
        end
    end

    // Instruction words
    always_ff @(posedge clk) begin
        if (push.valid) begin
            slots[push.warp] <= push.instr;
        end
    end

    // A warp never has a second word fetched before its first issues
    a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
        push.valid |-> !slot_full[push.warp]);

    // Executor only pops what it saw as full
    a_no_empty_pop: assert property (@(posedge clk) disable iff (reset)
        pop.valid |-> slot_full[pop.warp]);

endmodule

// ==== sources.f ====
+incdir+.
gpu_pkg.sv
warp_fetcher.sv
instr_buffer.sv
warp_executor.sv
compute_core.sv
tb_imem.sv
tb_compute_core.sv

// ==== tb_compute_core.sv ====
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module tb_compute_core import gpu_pkg::*; ();

    localparam int MAX_EXP = 64;
    localparam int LANE_BITS = `NUM_LANES * `DATA_WIDTH;

    logic clk;
    logic reset;
    logic start;
    core_cfg_t cfg;
    logic imem_valid;
    iaddr_t imem_address;
    logic imem_ready;
    instr_u imem_data;
    wb_t wb;
    logic done;

    // Kernel runs and their expected writebacks
    core_cfg_t run_cfg [4];
    int run_first [4];
    int run_end [4];
    warp_id_t exp_warp [MAX_EXP];
    reg_addr_t exp_rd [MAX_EXP];
    logic [LANE_BITS-1:0] exp_lanes [MAX_EXP];
    logic exp_after_sync [MAX_EXP];
    logic exp_seen [MAX_EXP];
    int n_runs;
    int n_exp;
    int n_words;
    int cur_run;
    int pre_sync_left;
    int errors;
    int checked;
    logic running;
    logic timed_out;

    compute_core uut (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .cfg          (cfg),
        .imem_valid   (imem_valid),
        .imem_address (imem_address),
        .imem_ready   (imem_ready),
        .imem_data    (imem_data),
        .wb           (wb),
        .done         (done)
    );

    tb_imem imem (
        .clk     (clk),
        .reset   (reset),
        .valid   (imem_valid),
        .address (imem_address),
        .ready   (imem_ready),
        .data    (imem_data)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [LANE_BITS-1:0] expected,
                               input logic [LANE_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_patterns();
        int fd;
        string line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] lane [4];
        logic [31:0] phase;
        fd = $fopen("compute_core_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open compute_core_patterns.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if (line[0] == "i") begin
                void'($sscanf(line, "i %h %h", a, b));
                imem.mem[a[`IADDR_WIDTH-1:0]] = b;
                n_words++;
            end else if (line[0] == "c") begin
                void'($sscanf(line, "c %h %h", a, b));
                run_cfg[n_runs].num_warps = a[2:0];
                run_cfg[n_runs].base_address = b[`IADDR_WIDTH-1:0];
                run_first[n_runs] = n_exp;
                run_end[n_runs] = n_exp;
                n_runs++;
            end else if (line[0] == "e" && n_runs > 0) begin
                void'($sscanf(line, "e %h %h %h %h %h %h %h", a, b,
                              lane[0], lane[1], lane[2], lane[3], phase));
                exp_warp[n_exp] = a[1:0];
                exp_rd[n_exp] = b[2:0];
                exp_lanes[n_exp] = {lane[3], lane[2], lane[1], lane[0]};
                exp_after_sync[n_exp] = phase[0];
                exp_seen[n_exp] = 1'b0;
                n_exp++;
                run_end[n_runs-1] = n_exp;
            end
        end
        $fclose(fd);
    endtask

    // Next unseen entry of that warp, so program order is enforced per warp
    task automatic match_writeback();
        int k;
        k = run_first[cur_run];
        while (k < run_end[cur_run] && (exp_seen[k] || exp_warp[k] != wb.warp)) begin
            k++;
        end
        if (k == run_end[cur_run]) begin
            $display("Unexpected writeback from warp %0d to r%0d in run %0d",
                     wb.warp, wb.rd, cur_run);
            errors++;
        end else begin
            exp_seen[k] = 1'b1;
            checked++;
            check_value("wb.rd", LANE_BITS'(exp_rd[k]), LANE_BITS'(wb.rd));
            check_value("wb.lanes", exp_lanes[k], wb.lanes);
            if (exp_after_sync[k] && pre_sync_left != 0) begin
                $display("Warp %0d passed the barrier with %0d earlier writebacks missing",
                         wb.warp, pre_sync_left);
                errors++;
            end
            if (!exp_after_sync[k]) begin
                pre_sync_left--;
            end
        end
    endtask

    always @(negedge clk) begin
        if (running && wb.valid) begin
            if (done) begin
                $display("Writeback from warp %0d arrived after done", wb.warp);
                errors++;
            end
            match_writeback();
        end
    end

    task automatic run_kernel(input int r);
        int limit;
        int cycles;
        int missing;
        limit = (run_end[r] - run_first[r] + n_words) * `NUM_WARPS * 16;
        cur_run = r;
        pre_sync_left = 0;
        missing = 0;
        for (int k = run_first[r]; k < run_end[r]; k++) begin
            if (!exp_after_sync[k]) begin
                pre_sync_left++;
            end
        end
        cfg = run_cfg[r];
        start = 1'b1;
        running = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (!done) begin
            $display("Timeout in run %0d, done never came within %0d cycles", r, limit);
            errors++;
            timed_out = 1'b1;
        end else begin
            for (int k = run_first[r]; k < run_end[r]; k++) begin
                if (!exp_seen[k]) begin
                    missing++;
                end
            end
            if (missing != 0) begin
                $display("done rose in run %0d with %0d writebacks missing", r, missing);
                errors++;
            end
            // Quiet window, the monitor flags any late strobe
            repeat (8) @(posedge clk);
            #2;
        end
        running = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        cfg = '0;
        n_runs = 0;
        n_exp = 0;
        n_words = 0;
        errors = 0;
        checked = 0;
        cur_run = 0;
        pre_sync_left = 0;
        running = 1'b0;
        timed_out = 1'b0;
        @(posedge clk);
        load_patterns();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        if (n_runs == 0) begin
            $display("No kernel runs found in the pattern file");
            errors++;
        end
        for (int r = 0; r < n_runs && !timed_out; r++) begin
            run_kernel(r);
        end
        $display("Checked %0d writebacks over %0d runs, %0d errors", checked, n_runs, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb_imem.sv ====
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module tb_imem import gpu_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   valid,
    input  iaddr_t address,
    output logic   ready,
    output instr_u data
);

    logic [31:0] mem [1 << `IADDR_WIDTH];
    integer seed;
    integer rnd;

    initial begin
        seed = 32'hbabf_a718;
        ready = 1'b0;
        // Unwritten words decode as HALT, low bits carry the address
        for (int a = 0; a < (1 << `IADDR_WIDTH); a++) begin
            mem[a] = {4'hf, 20'h0, a[`IADDR_WIDTH-1:0]};
        end
    end

    assign data = mem[address];

    // Random wait before each word is handed over
    always @(posedge clk) begin
        #2;
        rnd = $random(seed);
        ready = !reset && valid && rnd[1];
    end

endmodule

// ==== warp_executor.sv ====
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module warp_executor import gpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  core_cfg_t             cfg,
    input  logic [`NUM_WARPS-1:0] slot_full,
    input  instr_u                slots [`NUM_WARPS],
    output buf_pop_t              pop,
    output retire_t               retire,
    output wb_t                   wb,
    output logic                  done
);

    logic [`NUM_WARPS-1:0] launched;
    logic [`NUM_WARPS-1:0] halted;
    logic [`NUM_WARPS-1:0] barrier;
    logic [`NUM_WARPS-1:0] live;
    logic [`NUM_WARPS-1:0] release_mask;
    warp_id_t last_warp;

    logic issue_valid;
    warp_id_t issue_warp;
    instr_u ins;
    logic [3:0] op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    data_t imm_ext;
    logic writes_reg;
    logic [`NUM_LANES-1:0][`DATA_WIDTH-1:0] result;

    // Per-warp, per-lane vector registers
    data_t regs [`NUM_WARPS][`NUM_REGS][`NUM_LANES];

    // Issue
    assign issue_valid = |slot_full;
    assign issue_warp  = rr_pick(slot_full, last_warp);
    assign ins         = slots[issue_warp];

    assign pop.valid = issue_valid;
    assign pop.warp  = issue_warp;

    // Decode, register and immediate views of one word
    assign op  = ins.r.opcode;
    assign rd  = ins.r.rd;
    assign rs1 = ins.r.rs1;
    assign rs2 = ins.r.rs2;
    // Signed source, so the cast sign-extends
    assign imm_ext = data_t'(ins.i.imm);

    always_comb begin
        data_t a;
        data_t b;
        for (int l = 0; l < `NUM_LANES; l++) begin
            a = regs[issue_warp][rs1][l];
            b = regs[issue_warp][rs2][l];
            case (op)
                `OP_ADD:  result[l] = a + b;
                `OP_SUB:  result[l] = a - b;
                `OP_AND:  result[l] = a & b;
                `OP_XOR:  result[l] = a ^ b;
                `OP_ADDI: result[l] = a + imm_ext;
                `OP_TID:  result[l] = data_t'(issue_warp) * `NUM_LANES + data_t'(l);
                default:  result[l] = '0;
            endcase
        end
    end

    always_comb begin
        case (op)
            `OP_ADD, `OP_SUB, `OP_AND, `OP_XOR, `OP_ADDI, `OP_TID: writes_reg = 1'b1;
            default: writes_reg = 1'b0;
        endcase
    end

    // Barrier opens once every running warp has arrived
    assign live = launched & ~halted;
    assign release_mask = ((|barrier) && ((live & ~barrier) == '0)) ? (barrier & live) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            launched  <= '0;
            halted    <= '0;
            barrier   <= '0;
            last_warp <= '0;
            done      <= 1'b0;
            retire    <= '0;
            wb        <= '0;
            for (int w = 0; w < `NUM_WARPS; w++) begin
                for (int r = 0; r < `NUM_REGS; r++) begin
                    for (int l = 0; l < `NUM_LANES; l++) begin
                        regs[w][r][l] <= '0;
                    end
                end
            end
        end else begin
            wb.valid    <= 1'b0;
            retire.jump <= 1'b0;
            retire.mask <= release_mask;

            if (start) begin
                launched <= launch_mask(cfg.num_warps);
                halted   <= '0;
                barrier  <= '0;
                done     <= 1'b0;
            end else begin
                done <= (|launched) && (live == '0);

                if (|release_mask) begin
                    barrier <= '0;
                end

                if (issue_valid) begin
                    last_warp <= issue_warp;
                    case (op)
                        `OP_SYNC: barrier[issue_warp] <= 1'b1;
                        `OP_HALT: halted[issue_warp] <= 1'b1;
                        default:  retire.mask[issue_warp] <= 1'b1;
                    endcase

                    if (op == `OP_JAL) begin
                        retire.jump        <= 1'b1;
                        retire.jump_warp   <= issue_warp;
                        retire.jump_target <= iaddr_t'(ins.i.imm);
                    end

                    if (writes_reg) begin
                        for (int l = 0; l < `NUM_LANES; l++) begin
                            regs[issue_warp][rd][l] <= result[l];
                        end
                        wb.valid <= 1'b1;
                        wb.warp  <= issue_warp;
                        wb.rd    <= rd;
                        wb.lanes <= result;
                    end
                end
            end
        end
    end

    // Halted warps are never retired, so the fetcher never refills them
    a_no_halted_issue: assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> !halted[issue_warp]);

endmodule

// ==== warp_fetcher.sv ====
`timescale 1ns/1ps
`include "gpu_cfg.svh"

module warp_fetcher import gpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  core_cfg_t             cfg,
    output logic                  imem_valid,
    output iaddr_t                imem_address,
    input  logic                  imem_ready,
    input  instr_u                imem_data,
    input  logic [`NUM_WARPS-1:0] slot_full,
    input  retire_t               retire,
    output buf_push_t             push
);

    iaddr_t pc [`NUM_WARPS];
    logic [`NUM_WARPS-1:0] launched;
    logic [`NUM_WARPS-1:0] pending;
    logic [`NUM_WARPS-1:0] eligible;
    warp_id_t req_warp;
    warp_id_t last_warp;
    warp_id_t pick;
    logic can_request;
    logic xfer;

    // One instruction in flight per warp
    assign eligible = launched & ~pending & ~slot_full;
    assign pick = rr_pick(eligible, last_warp);

    assign xfer = imem_valid && imem_ready;

    // Next request may go out in the cycle the current one completes
    assign can_request = !start && (|eligible) && (!imem_valid || imem_ready);

    // Fetched word goes straight into the warp's slot
    assign push.valid = xfer;
    assign push.warp  = req_warp;
    assign push.instr = imem_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            launched     <= '0;
            pending      <= '0;
            imem_valid   <= 1'b0;
            imem_address <= '0;
            req_warp     <= '0;
            last_warp    <= '0;
            for (int w = 0; w < `NUM_WARPS; w++) begin
                pc[w] <= '0;
            end
        end else begin
            if (xfer) begin
                imem_valid <= 1'b0;
            end

            if (start) begin
                launched <= launch_mask(cfg.num_warps);
                pending  <= '0;
                for (int w = 0; w < `NUM_WARPS; w++) begin
                    pc[w] <= cfg.base_address;
                end
            end else begin
                // Retired warps advance or take the jump
                for (int w = 0; w < `NUM_WARPS; w++) begin
                    if (retire.mask[w]) begin
                        pending[w] <= 1'b0;
                        if (retire.jump && retire.jump_warp == warp_id_t'(w)) begin
                            pc[w] <= retire.jump_target;
                        end else begin
                            pc[w] <= pc[w] + 1'b1;
                        end
                    end
                end

                if (can_request) begin
                    imem_valid     <= 1'b1;
                    imem_address   <= pc[pick];
                    req_warp       <= pick;
                    last_warp      <= pick;
                    pending[pick]  <= 1'b1;
                end
            end
        end
    end

    // Request held until the memory takes it
    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        imem_valid && !imem_ready |=> imem_valid && $stable(imem_address));

endmodule
